//--- hdl/aluPkg.sv
// ALU package with the datapath widths, the opcode and shift-mode encodings and the request/response structs
package aluPkg;

    localparam int DataWidth   = 8;
    localparam int ShamtWidth  = 3;    // Amount bits that form a partial shift
    localparam int NibbleWidth = 4;    // Multiplier operand width

    // One ALU word, signed like the reference operands
    typedef logic signed [DataWidth-1:0] dataT;

    // Opcode values follow the reference mux select codes
    typedef enum logic [2:0] {
        OpForward = 3'd0,
        OpAdd     = 3'd1,
        OpAnd     = 3'd2,
        OpOr      = 3'd3,
        OpShift   = 3'd4,    // Logical, direction from shiftLeft
        OpSra     = 3'd5,
        OpRor     = 3'd6,
        OpMul     = 3'd7     // Signed low-nibble multiply
    } aluOpT;

    // Mode seen by the barrel shifter
    typedef enum logic [1:0] {
        ShiftLeft         = 2'd0,
        ShiftRightLogical = 2'd1,
        ShiftRightArith   = 2'd2,
        RotateRight       = 2'd3
    } shiftModeT;

    // Request presented with reqValid
    typedef struct packed {
        aluOpT opcode;
        dataT  operandA;
        dataT  operandB;    // Also the shift or rotate amount
        logic  shiftLeft;   // Only meaningful with OpShift
    } aluReqT;

    // Registered response
    typedef struct packed {
        dataT result;
        logic zero;         // Add result was zero
    } aluRespT;

endpackage

//--- hdl/shiftUnit.sv
// Barrel shifter for logical left/right, arithmetic right and rotate right by an 8-bit amount
`timescale 1ns/10ps

module shiftUnit (
    input  aluPkg::dataT      value,
    input  aluPkg::dataT      amount,
    input  aluPkg::shiftModeT mode,
    output aluPkg::dataT      shifted
);

    import aluPkg::*;

    // One shifter stage by a fixed distance
    function automatic dataT shiftStep(dataT v, int unsigned k, shiftModeT m);
        dataT r;
        unique case (m)
            ShiftLeft:         r = v << k;
            ShiftRightLogical: r = v >> k;
            ShiftRightArith:   r = v >>> k;    // Sign fills in as v is signed
            RotateRight:       r = (v >> k) | (v << (DataWidth - k));
            default:           r = v;
        endcase
        return r;
    endfunction

    dataT stage [ShamtWidth + 1];    // stage[0] is the input value
    logic bigShift;                  // Amount of 8 or more

    // Stages by 1, 2 and 4 enabled by one amount bit each
    always_comb
    begin
        stage[0] = value;
        for (int s = 0; s < ShamtWidth; s++)
        begin
            if (amount[s])
                stage[s + 1] = shiftStep(stage[s], 1 << s, mode);
            else
                stage[s + 1] = stage[s];
        end
    end

    assign bigShift = |amount[DataWidth-1:ShamtWidth];

    // Final stage for shifts that push every bit out
    always_comb
    begin
        if (!bigShift || mode == RotateRight)
        begin
            // Rotate only looks at the low amount bits
            shifted = stage[ShamtWidth];
        end
        else if (mode == ShiftRightArith)
        begin
            shifted = {DataWidth{value[DataWidth-1]}};    // All sign bits
        end
        else
        begin
            shifted = '0;
        end
    end

    // Rotate never gains or loses a set bit
    always_comb
    begin
        assert final ($isunknown({value, amount, mode})
                      || mode != RotateRight
                      || $countones(shifted) == $countones(value))
        else
            $error("rotate changed the bit count of %h to %h", value, shifted);
    end

endmodule

//--- hdl/nibbleMultiplier.sv
// Signed 4x4 Baugh-Wooley multiplier producing an 8-bit two's-complement product
`timescale 1ns/10ps

module nibbleMultiplier (
    input  logic signed [aluPkg::NibbleWidth-1:0] multiplicand,
    input  logic signed [aluPkg::NibbleWidth-1:0] multiplier,
    output aluPkg::dataT                          product
);

    import aluPkg::*;

    dataT rows [NibbleWidth];    // One partial-product row per multiplier bit

    // Partial products, already placed at their weight
    always_comb
    begin
        logic pp;
        for (int j = 0; j < NibbleWidth; j++)
        begin
            rows[j] = '0;
            for (int i = 0; i < NibbleWidth; i++)
            begin
                pp = multiplicand[i] & multiplier[j];
                // Sign row and sign column terms go inverted, except their crossing
                if ((i == NibbleWidth - 1) != (j == NibbleWidth - 1))
                    pp = ~pp;
                rows[j][i + j] = pp;
            end
        end
    end

    // Row-by-row accumulation, seeded with the correction ones
    always_comb
    begin
        dataT acc;
        acc = '0;
        acc[NibbleWidth]   = 1'b1;    // 2^n
        acc[DataWidth - 1] = 1'b1;    // 2^(2n-1)
        for (int j = 0; j < NibbleWidth; j++)
        begin
            acc = acc + rows[j];     // Carry out of bit 7 is dropped
        end
        product = acc;
    end

    // Gate-style product must agree with a plain signed multiply
    always_comb
    begin
        assert final ($isunknown({multiplicand, multiplier})
                      || product == dataT'(multiplicand) * dataT'(multiplier))
        else
            $error("product %h wrong for %0d * %0d", product, multiplicand, multiplier);
    end

endmodule

//--- hdl/aluDatapath.sv
// ALU datapath with the functional units, result select and zero flag, fully combinational
`timescale 1ns/10ps

module aluDatapath (
    input  aluPkg::aluReqT  req,
    output aluPkg::aluRespT resp
);

    import aluPkg::*;

    dataT      sum;          // Add unit, carry dropped
    dataT      shiftOut;
    dataT      mulOut;
    shiftModeT shiftMode;

    assign sum = req.operandA + req.operandB;

    // Opcode plus direction bit pick the shifter mode
    always_comb
    begin
        case (req.opcode)
            OpShift:
            begin
                if (req.shiftLeft)
                    shiftMode = ShiftLeft;
                else
                    shiftMode = ShiftRightLogical;
            end
            OpSra:   shiftMode = ShiftRightArith;
            default: shiftMode = RotateRight;    // OpRor, don't care otherwise
        endcase
    end

    // Shared shifter for OpShift, OpSra and OpRor
    shiftUnit uShift (
        .value   (req.operandA),
        .amount  (req.operandB),
        .mode    (shiftMode),
        .shifted (shiftOut)
    );

    // Low nibbles only
    nibbleMultiplier uMul (
        .multiplicand (req.operandA[NibbleWidth-1:0]),
        .multiplier   (req.operandB[NibbleWidth-1:0]),
        .product      (mulOut)
    );

    // Result mux and zero flag
    always_comb
    begin
        case (req.opcode)
            OpForward: resp.result = req.operandB;
            OpAdd:     resp.result = sum;
            OpAnd:     resp.result = req.operandA & req.operandB;
            OpOr:      resp.result = req.operandA | req.operandB;
            OpShift:   resp.result = shiftOut;
            OpSra:     resp.result = shiftOut;
            OpRor:     resp.result = shiftOut;
            OpMul:     resp.result = mulOut;
            default:   resp.result = 'x;
        endcase

        // Only an add can raise the flag
        resp.zero = (req.opcode == OpAdd) && (sum == '0);
    end

    // A clean request must never leave an unknown result through any unit
    always_comb
    begin
        assert final ($isunknown(req) || !$isunknown(resp.result))
        else
            $error("unknown result for opcode %0d", req.opcode);
    end

endmodule

//--- hdl/aluTop.sv
// ALU top that samples the request strobe and registers the datapath response
`timescale 1ns/10ps

module aluTop (
    input  logic            clk,
    input  logic            rst,
    input  logic            reqValid,
    input  aluPkg::aluReqT  req,
    output logic            respValid,
    output aluPkg::aluRespT resp
);

    import aluPkg::*;

    aluRespT dpResp;    // Combinational datapath result
    aluOpT   lastOp;    // Opcode behind the held resp

    aluDatapath uDatapath (
        .req  (req),
        .resp (dpResp)
    );

    // Register stage that only loads resp on a sampled strobe
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            respValid <= 1'b0;
            resp      <= '0;
            lastOp    <= OpForward;
        end
        else
        begin
            respValid <= reqValid;
            if (reqValid)
            begin
                resp   <= dpResp;
                lastOp <= req.opcode;
            end
        end
    end

    // A raised flag always comes with a zero result
    assert property (@(posedge clk) disable iff (rst)
        resp.zero |-> (resp.result == '0))
    else
        $error("zero flag set with result %h", resp.result);

    // Flag only ever comes from an add
    assert property (@(posedge clk) disable iff (rst)
        resp.zero |-> (lastOp == OpAdd))
    else
        $error("zero flag set for opcode %0d", lastOp);

endmodule

//--- dv/aluModel.svh
// ALU reference model and the Galois LFSR used for the random stimulus
`ifndef ALU_MODEL_SVH
`define ALU_MODEL_SVH

// 16-bit Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
function automatic logic [15:0] lfsrNext(logic [15:0] state);
    logic [15:0] next;
    next = state >> 1;
    if (state[0])
        next = next ^ 16'hB400;    // Feedback taps
    return next;
endfunction

// Low nibble read as 4-bit two's complement
function automatic int nibbleValue(dataT word);
    int v;
    v = int'(word[3:0]);
    if (word[3])
        v = v - 16;
    return v;
endfunction

// Expected response for one request
function automatic aluRespT aluExpected(aluReqT r);
    aluRespT     e;
    int unsigned amt;
    logic [15:0] twice;
    dataT        sum;
    amt   = int'($unsigned(r.operandB));    // Whole operand B as amount
    twice = {r.operandA, r.operandA};
    sum   = dataT'(int'(r.operandA) + int'(r.operandB));
    case (r.opcode)
        OpForward: e.result = r.operandB;
        OpAdd:     e.result = sum;               // Carry out dropped
        OpAnd:     e.result = r.operandA & r.operandB;
        OpOr:      e.result = r.operandA | r.operandB;
        OpShift:
        begin
            if (amt >= 8)
                e.result = '0;                   // Everything pushed out
            else if (r.shiftLeft)
                e.result = r.operandA << amt;
            else
                e.result = $unsigned(r.operandA) >> amt;
        end
        OpSra:     e.result = dataT'(int'(r.operandA) >>> ((amt >= 8) ? 8 : amt));
        OpRor:     e.result = dataT'(twice >> (amt % 8));    // High bits ignored
        OpMul:     e.result = dataT'(nibbleValue(r.operandA) * nibbleValue(r.operandB));
        default:   e.result = 'x;
    endcase
    e.zero = (r.opcode == OpAdd) && (sum == 0);
    return e;
endfunction

`endif

//--- dv/aluTb.sv
// Testbench for the clocked ALU with random requests checked against a reference model
`timescale 1ns/10ps

module aluTb;

    import aluPkg::*;

    `include "aluModel.svh"

    localparam int ResetCycles  = 10;
    localparam int NumCycles    = 2000;    // Random stimulus cycles
    localparam int ResetTimeout = 20;
    localparam int DrainTimeout = 20;

    logic    clk;
    logic    rst;
    logic    reqValid;
    aluReqT  req;
    logic    respValid;
    aluRespT resp;

    logic [15:0] lfsrState;
    aluRespT     expected [$];    // One entry per request in flight

    int checkCount;
    int mismatchErrors;
    int protocolErrors;
    int timeoutErrors;

    aluTop DUT (
        .clk       (clk),
        .rst       (rst),
        .reqValid  (reqValid),
        .req       (req),
        .respValid (respValid),
        .resp      (resp)
    );

    always #50 clk = ~clk;

    // Takes n bits off the LFSR, one step per bit
    function automatic logic [7:0] takeBits(int n);
        logic [7:0] bits;
        bits = '0;
        for (int i = 0; i < n; i++)
        begin
            bits      = {bits[6:0], lfsrState[0]};
            lfsrState = lfsrNext(lfsrState);
        end
        return bits;
    endfunction

    task automatic checkResult(string name, dataT expVal, dataT actVal);
        checkCount++;
        if (actVal !== expVal)
        begin
            mismatchErrors++;
            $display("mismatch at %0t: %s expected %h actual %h", $time, name, expVal, actVal);
        end
    endtask

    task automatic checkZero(string name, logic expVal, logic actVal);
        checkCount++;
        if (actVal !== expVal)
        begin
            mismatchErrors++;
            $display("mismatch at %0t: %s expected %b actual %b", $time, name, expVal, actVal);
        end
    endtask

    task automatic randomRequest(output logic valid, output aluReqT r);
        valid       = (takeBits(2) != 0);    // About 3 in 4
        r.opcode    = aluOpT'(takeBits(3));
        r.operandA  = dataT'(takeBits(8));
        r.operandB  = dataT'(takeBits(8));
        r.shiftLeft = takeBits(1) != 0;
        // Short amounts, otherwise nearly every shift is 8 or more
        if ((r.opcode == OpShift || r.opcode == OpSra) && takeBits(1) != 0)
            r.operandB = {5'b0, r.operandB[2:0]};
        // A and minus A so the zero flag fires
        if (takeBits(3) == 0)
        begin
            r.opcode   = OpAdd;
            r.operandB = -r.operandA;
        end
    endtask

    // Checks the response of the last edge, then records and drives requests
    task automatic serviceEdge(input bit driveNew);
        aluRespT exp;
        aluReqT  nextReq;
        logic    nextValid;
        if (respValid === 1'b1)
        begin
            if (expected.size() == 0)
            begin
                protocolErrors++;
                $display("At %0t respValid went high with no request outstanding", $time);
            end
            else
            begin
                exp = expected.pop_front();
                checkResult("resp.result", exp.result, resp.result);
                checkZero("resp.zero", exp.zero, resp.zero);
            end
        end
        else if (respValid !== 1'b0)
        begin
            protocolErrors++;
            $display("At %0t respValid is unknown", $time);
        end
        else if (expected.size() != 0)
        begin
            protocolErrors++;
            $display("At %0t a response is missing one cycle after its request", $time);
            void'(expected.pop_front());
        end

        if (reqValid)
            expected.push_back(aluExpected(req));    // Sampled by the DUT at this edge

        if (driveNew)
        begin
            randomRequest(nextValid, nextReq);
            reqValid <= nextValid;
            req      <= nextReq;
        end
        else
        begin
            reqValid <= 1'b0;
        end
    endtask

    task automatic holdReset();
        for (int c = 1; c <= ResetCycles; c++)
        begin
            @(posedge clk);
            if (c > 1 && respValid !== 1'b0)    // First edge still loads the reset
            begin
                protocolErrors++;
                $display("At %0t respValid is not low during reset", $time);
            end
        end
        rst <= 1'b0;
    endtask

    task automatic waitResetRelease(output bit ok);
        int cycles;
        ok     = 1'b0;
        cycles = 0;
        while (!ok && cycles < ResetTimeout)
        begin
            @(posedge clk);
            cycles++;
            if (rst === 1'b0)
                ok = 1'b1;
        end
        if (!ok)
        begin
            timeoutErrors++;
            $display("Timed out waiting for reset to be released");
        end
    endtask

    task automatic drainQueue(output bit ok);
        int cycles;
        cycles = 0;
        while (expected.size() != 0 && cycles < DrainTimeout)
        begin
            @(posedge clk);
            cycles++;
            serviceEdge(1'b0);
        end
        ok = (expected.size() == 0);
        if (!ok)
        begin
            timeoutErrors++;
            $display("Timed out with %0d responses still outstanding", expected.size());
        end
    endtask

    task automatic finishRun();
        $display("Checks: %0d, mismatches: %0d, protocol errors: %0d, timeouts: %0d",
                 checkCount, mismatchErrors, protocolErrors, timeoutErrors);
        if (mismatchErrors + protocolErrors + timeoutErrors == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    endtask

    initial
    begin
        bit ok;
        clk            = 1'b0;
        rst            = 1'b1;
        reqValid       = 1'b0;
        req            = '0;
        lfsrState      = 16'd58;
        checkCount     = 0;
        mismatchErrors = 0;
        protocolErrors = 0;
        timeoutErrors  = 0;

        holdReset();
        waitResetRelease(ok);
        if (ok)
        begin
            // Register state left by reset
            checkResult("resp.result", '0, resp.result);
            checkZero("resp.zero", 1'b0, resp.zero);
            checkZero("respValid", 1'b0, respValid);

            for (int c = 0; c < NumCycles; c++)
            begin
                @(posedge clk);
                serviceEdge(1'b1);
            end
            drainQueue(ok);

            // A couple of idle cycles, no stray responses
            for (int c = 0; c < 2; c++)
            begin
                @(posedge clk);
                serviceEdge(1'b0);
            end
        end
        finishRun();
    end

endmodule

//--- tb.f
+incdir+dv
hdl/aluPkg.sv
hdl/shiftUnit.sv
hdl/nibbleMultiplier.sv
hdl/aluDatapath.sv
hdl/aluTop.sv
dv/aluTb.sv

//--- Bender.yml
package:
  name: alu8

sources:
  # RTL in compile order
  - files:
      - hdl/aluPkg.sv
      - hdl/shiftUnit.sv
      - hdl/nibbleMultiplier.sv
      - hdl/aluDatapath.sv
      - hdl/aluTop.sv

  # Testbench, top module aluTb
  - target: test
    include_dirs:
      - dv
    files:
      - dv/aluTb.sv
